//--- Makefile
# Verilator build and run for the memory mapper testbench

VERILATOR  ?= verilator
TOP        ?= memory_mapper_tb
FILE_LIST  ?= sim.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_TEXT  ?= STATUS: PASS
SIM_ARGS   ?= +verilator+error+limit+100
VFLAGS     ?= --binary --timing --assert --timescale 1ns/1ns
LINT_FLAGS ?= --lint-only --timing --assert -Wall --timescale 1ns/1ns

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard hw/*.sv tb/*.sv include/*.svh)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILE_LIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: $(SIM_BIN)
	$(SIM_BIN) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "^$(PASS_TEXT)$$" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- hw/mapper_bus_pkg.sv
// CPU side types for the memory mapper, address, data and I/O cycle
`default_nettype none

package mapper_bus_pkg;

    typedef logic [15:0] cpu_addr_t;
    typedef logic [7:0]  cpu_data_t;

    // One CPU I/O cycle as seen by the mapper ports
    typedef struct packed {
        logic      iorq;
        logic      m1;      // High with iorq during interrupt acknowledge
        logic      rd;
        logic      wr;
        cpu_addr_t addr;    // Only the low byte selects the port
        cpu_data_t wr_data;
    } io_cycle_t;

endpackage

`default_nettype wire

//--- hw/mapper_config_pkg.sv
// Mapper side types, segment numbers, per-mapper configuration and memory lookups
`default_nettype none

`include "mapper_settings.svh"

package mapper_config_pkg;

    import mapper_bus_pkg::*;

    typedef logic [`SEG_WIDTH-1:0]       segment_t;
    typedef logic [1:0]                  mapper_index_t;
    typedef logic [`PHYS_ADDR_WIDTH-1:0] phys_addr_t;

    // Static setup of one mapper
    typedef struct packed {
        logic       enable;
        logic [7:0] port_base;  // Usually FC for the four ports FC to FF
        logic [7:0] port_mask;  // Set bits must match port_base
        segment_t   size;       // Segment count, zero means 256
    } mapper_cfg_t;

    // Memory access to translate
    typedef struct packed {
        logic          valid;
        mapper_index_t index;   // Mapper chosen by the slot logic
        cpu_addr_t     addr;
    } mem_lookup_t;

endpackage

`default_nettype wire

//--- hw/mapper_io_decoder.sv
// I/O port decoder that turns CPU I/O cycles into per-mapper read and write strobes
`timescale 1ns/1ns
`default_nettype none

`include "mapper_settings.svh"

module mapper_io_decoder
    import mapper_bus_pkg::*, mapper_config_pkg::*;
(
    input  io_cycle_t                io_cycle,
    input  mapper_cfg_t              cfg [`MAPPER_COUNT],
    output logic [`MAPPER_COUNT-1:0] hit,
    output logic [`MAPPER_COUNT-1:0] rd_strobe,
    output logic [`MAPPER_COUNT-1:0] wr_strobe,
    output logic [1:0]               reg_index
);

    logic                     io_eligible;
    logic [7:0]               port;
    logic [`MAPPER_COUNT-1:0] in_window;

    // A real I/O access, not an interrupt acknowledge
    assign io_eligible = io_cycle.iorq & ~io_cycle.m1;
    assign port        = io_cycle.addr[7:0];

    genvar i;
    generate
        for (i = 0; i < `MAPPER_COUNT; i++) begin : g_match
            // Compare only the bits the mask keeps
            assign in_window[i] = ((port ^ cfg[i].port_base) & cfg[i].port_mask) == 8'h00;

            assign hit[i] = cfg[i].enable & io_eligible & in_window[i];
        end
    endgenerate

    // Strobes are plain levels for the current cycle
    assign rd_strobe = hit & {`MAPPER_COUNT{io_cycle.rd}};
    assign wr_strobe = hit & {`MAPPER_COUNT{io_cycle.wr}};

    // Four ports per mapper, one per 16 KiB page
    assign reg_index = io_cycle.addr[1:0];

endmodule

`default_nettype wire

//--- hw/mapper_response.sv
// Response stage that merges mapper reads and forms the translated RAM address
`timescale 1ns/1ns
`default_nettype none

`include "mapper_settings.svh"

module mapper_response
    import mapper_bus_pkg::*, mapper_config_pkg::*;
(
    input  io_cycle_t                io_cycle,
    input  logic [`MAPPER_COUNT-1:0] hit,
    input  cpu_data_t                rd_data [`MAPPER_COUNT],
    input  segment_t                 page_segment [`MAPPER_COUNT],
    input  mem_lookup_t              mem_lookup,
    output logic                     read_rq,
    output cpu_data_t                read_data,
    output phys_addr_t               phys_addr,
    output segment_t                 page_segment_out
);

    // Wired AND of the data bus, idle mappers drive FF
    always_comb begin
        read_data = '1;
        for (int i = 0; i < `MAPPER_COUNT; i++) begin
            read_data &= rd_data[i];
        end
    end

    // hit already includes the iorq and m1 checks
    assign read_rq = io_cycle.rd & (|hit);

    // Mapper select, an index beyond the mapper count leaves all ones
    always_comb begin
        page_segment_out = '1;
        if (mem_lookup.valid) begin
            for (int i = 0; i < `MAPPER_COUNT; i++) begin
                if (mem_lookup.index == mapper_index_t'(i)) begin
                    page_segment_out = page_segment[i];
                end
            end
        end
    end

    // Segment becomes the upper physical address bits
    assign phys_addr = {page_segment_out, mem_lookup.addr[`PAGE_OFFSET_WIDTH-1:0]};

endmodule

`default_nettype wire

//--- hw/mapper_segment_bank.sv
// Segment register bank of one mapper with size limited write and read
`timescale 1ns/1ns
`default_nettype none

module mapper_segment_bank
    import mapper_bus_pkg::*, mapper_config_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       rd_strobe,
    input  logic       wr_strobe,
    input  logic [1:0] reg_index,
    input  cpu_data_t  wr_data,
    input  segment_t   size,
    input  logic [1:0] mem_page,
    output cpu_data_t  rd_data,
    output segment_t   page_segment
);

    segment_t seg_reg [4];  // One segment per page
    segment_t seg_mask;

    // Size zero wraps to FF, which keeps all 256 segments
    assign seg_mask = size - segment_t'(1);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 4; i++) begin
                seg_reg[i] <= '0;
            end
        end else if (wr_strobe) begin
            seg_reg[reg_index] <= segment_t'(wr_data) & seg_mask; // Drop bits beyond size
        end
    end

    // Unused upper bits read back as ones, idle bank drives all ones
    assign rd_data = rd_strobe ? cpu_data_t'(seg_reg[reg_index] | ~seg_mask) : '1;

    assign page_segment = seg_reg[mem_page]; // Raw value for address translation

endmodule

`default_nettype wire

//--- hw/memory_mapper_top.sv
// Memory mapper top level with port decoder, segment banks and response stage
`timescale 1ns/1ns
`default_nettype none

`include "mapper_settings.svh"

module memory_mapper_top
    import mapper_bus_pkg::*, mapper_config_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  io_cycle_t   io_cycle,
    input  mapper_cfg_t cfg [`MAPPER_COUNT],
    input  mem_lookup_t mem_lookup,
    output logic        read_rq,
    output cpu_data_t   read_data,
    output phys_addr_t  phys_addr,
    output segment_t    page_segment
);

    logic [`MAPPER_COUNT-1:0] hit;
    logic [`MAPPER_COUNT-1:0] rd_strobe;
    logic [`MAPPER_COUNT-1:0] wr_strobe;
    logic [1:0]               reg_index;    // Shared by all banks

    cpu_data_t bank_rd_data [`MAPPER_COUNT];
    segment_t  bank_page_segment [`MAPPER_COUNT];

    mapper_io_decoder i_decoder (
        .io_cycle  (io_cycle),
        .cfg       (cfg),
        .hit       (hit),
        .rd_strobe (rd_strobe),
        .wr_strobe (wr_strobe),
        .reg_index (reg_index)
    );

    genvar i;
    generate
        for (i = 0; i < `MAPPER_COUNT; i++) begin : g_bank
            mapper_segment_bank i_bank (
                .clk          (clk),
                .reset        (reset),
                .rd_strobe    (rd_strobe[i]),
                .wr_strobe    (wr_strobe[i]),
                .reg_index    (reg_index),
                .wr_data      (io_cycle.wr_data),
                .size         (cfg[i].size),
                .mem_page     (mem_lookup.addr[15:14]), // Page of the memory access
                .rd_data      (bank_rd_data[i]),
                .page_segment (bank_page_segment[i])
            );
        end
    endgenerate

    mapper_response i_response (
        .io_cycle         (io_cycle),
        .hit              (hit),
        .rd_data          (bank_rd_data),
        .page_segment     (bank_page_segment),
        .mem_lookup       (mem_lookup),
        .read_rq          (read_rq),
        .read_data        (read_data),
        .phys_addr        (phys_addr),
        .page_segment_out (page_segment)
    );

endmodule

`default_nettype wire

//--- include/mapper_settings.svh
// Memory mapper sizing macros shared by the packages and the RTL
`ifndef MAPPER_SETTINGS_SVH
`define MAPPER_SETTINGS_SVH

// Independent mappers sharing the CPU I/O bus
`define MAPPER_COUNT 3

`define SEG_WIDTH 8 // Up to 256 segments

// 16 KiB pages, so 14 offset bits below the page number
`define PAGE_OFFSET_WIDTH 14

`define PHYS_ADDR_WIDTH (`SEG_WIDTH + `PAGE_OFFSET_WIDTH) // 4 MiB of RAM

`endif

//--- sim.f
+incdir+include
hw/mapper_bus_pkg.sv
hw/mapper_config_pkg.sv
hw/mapper_io_decoder.sv
hw/mapper_segment_bank.sv
hw/mapper_response.sv
hw/memory_mapper_top.sv
tb/memory_mapper_properties.sv
tb/memory_mapper_tb.sv

//--- tb/memory_mapper_properties.sv
// Bound checks on memory mapper strobe exclusivity and reset behaviour
`timescale 1ns/1ns
`default_nettype none

`include "mapper_settings.svh"

module memory_mapper_properties
    import mapper_bus_pkg::*;
(
    input logic                     clk,
    input logic                     reset,
    input io_cycle_t                io_cycle,
    input logic [`MAPPER_COUNT-1:0] rd_strobe,
    input logic [`MAPPER_COUNT-1:0] wr_strobe,
    input logic                     read_rq
);

    int failure_count = 0;

    genvar i;
    generate
        for (i = 0; i < `MAPPER_COUNT; i++) begin : g_strobe
            // A bus cycle is either a read or a write
            assert property (@(posedge clk) !(rd_strobe[i] && wr_strobe[i]))
                else begin
                    failure_count++;
                    $error("Read and write strobes overlap for mapper %0d", i);
                end
        end
    endgenerate

    // Idle I/O inputs keep the request low while in reset
    assert property (@(posedge clk) (reset && !io_cycle.iorq) |-> !read_rq)
        else begin
            failure_count++;
            $error("read_rq is high during reset with the I/O bus idle");
        end

endmodule

`default_nettype wire

//--- tb/memory_mapper_tb.sv
// Testbench for the memory mapper with shadow registers and assertion checking
`timescale 1ns/1ns
`default_nettype none

`include "mapper_settings.svh"

module memory_mapper_tb
    import mapper_bus_pkg::*, mapper_config_pkg::*;
();

    localparam int RESET_CYCLES   = 10;
    localparam int NUM_PAIRS      = 40;  // Write then read
    localparam int NUM_IGNORED    = 30;
    localparam int NUM_LOOKUPS    = 40;
    localparam int NUM_OPS        = 4 + 2 * NUM_PAIRS + NUM_IGNORED + NUM_LOOKUPS + 4;
    localparam int TIMEOUT_CYCLES = 2 * NUM_OPS * 4;
    localparam logic [31:0] RANDOM_SEED = 32'he2f6_1b50;

    logic        clk;
    logic        reset;
    io_cycle_t   io_cycle;
    mapper_cfg_t cfg [`MAPPER_COUNT];
    mem_lookup_t mem_lookup;
    logic        read_rq;
    cpu_data_t   read_data;
    phys_addr_t  phys_addr;
    segment_t    page_segment;

    segment_t                 shadow [`MAPPER_COUNT][4];
    logic [`MAPPER_COUNT-1:0] exp_hit;
    logic                     exp_read_rq;
    cpu_data_t                exp_read_data;
    segment_t                 exp_page_segment;
    phys_addr_t               exp_phys_addr;

    int   error_count = 0;
    int   cycle_count = 0;
    logic timed_out   = 1'b0;

    memory_mapper_top i_dut (
        .clk          (clk),
        .reset        (reset),
        .io_cycle     (io_cycle),
        .cfg          (cfg),
        .mem_lookup   (mem_lookup),
        .read_rq      (read_rq),
        .read_data    (read_data),
        .phys_addr    (phys_addr),
        .page_segment (page_segment)
    );

    bind memory_mapper_top memory_mapper_properties i_props (
        .clk       (clk),
        .reset     (reset),
        .io_cycle  (io_cycle),
        .rd_strobe (rd_strobe),
        .wr_strobe (wr_strobe),
        .read_rq   (read_rq)
    );

    always #20 clk = ~clk;

    // Kept segment bits, size zero gives all 256
    function automatic segment_t size_mask(input segment_t size);
        return size - 8'd1;
    endfunction

    // Expected responses from the port window and size rules
    always_comb begin
        exp_hit       = '0;
        exp_read_data = 8'hFF;
        for (int m = 0; m < `MAPPER_COUNT; m++) begin
            exp_hit[m] = cfg[m].enable && io_cycle.iorq && !io_cycle.m1
                && ((io_cycle.addr[7:0] & cfg[m].port_mask)
                    == (cfg[m].port_base & cfg[m].port_mask));
            if (exp_hit[m] && io_cycle.rd) begin
                exp_read_data &= shadow[m][io_cycle.addr[1:0]] | ~size_mask(cfg[m].size);
            end
        end
        exp_read_rq      = io_cycle.rd && (|exp_hit);
        exp_page_segment = 8'hFF;
        if (mem_lookup.valid && int'(mem_lookup.index) < `MAPPER_COUNT) begin
            exp_page_segment = shadow[mem_lookup.index][mem_lookup.addr[15:14]];
        end
        exp_phys_addr = {exp_page_segment, mem_lookup.addr[13:0]};
    end

    always @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int m = 0; m < `MAPPER_COUNT; m++) begin
                for (int p = 0; p < 4; p++) begin
                    shadow[m][p] <= '0;
                end
            end
        end else begin
            for (int m = 0; m < `MAPPER_COUNT; m++) begin
                if (exp_hit[m] && io_cycle.wr) begin
                    shadow[m][io_cycle.addr[1:0]] <= io_cycle.wr_data & size_mask(cfg[m].size);
                end
            end
        end
    end

    assert property (@(posedge clk) disable iff (reset) read_data == exp_read_data)
        else begin
            error_count++;
            $display("FAILED at %0t: read_data got %h, expected %h",
                     $time, $sampled(read_data), $sampled(exp_read_data));
        end

    assert property (@(posedge clk) disable iff (reset) read_rq == exp_read_rq)
        else begin
            error_count++;
            $display("FAILED at %0t: read_rq got %b, expected %b",
                     $time, $sampled(read_rq), $sampled(exp_read_rq));
        end

    assert property (@(posedge clk) disable iff (reset) page_segment == exp_page_segment)
        else begin
            error_count++;
            $display("FAILED at %0t: page_segment got %h, expected %h",
                     $time, $sampled(page_segment), $sampled(exp_page_segment));
        end

    assert property (@(posedge clk) disable iff (reset) phys_addr == exp_phys_addr)
        else begin
            error_count++;
            $display("FAILED at %0t: phys_addr got %h, expected %h",
                     $time, $sampled(phys_addr), $sampled(exp_phys_addr));
        end

    task automatic randomize_lookup(input logic valid);
        mem_lookup.valid = valid;
        mem_lookup.index = mapper_index_t'($urandom_range(0, `MAPPER_COUNT - 1));
        mem_lookup.addr  = cpu_addr_t'($urandom);
    endtask

    // One bus cycle, then back to idle
    task automatic io_access(input logic iorq, input logic m1, input logic rd,
                             input logic wr, input logic [7:0] port, input cpu_data_t data);
        @(negedge clk);
        io_cycle.iorq    = iorq;
        io_cycle.m1      = m1;
        io_cycle.rd      = rd;
        io_cycle.wr      = wr;
        io_cycle.addr    = {8'($urandom), port};  // Upper byte is not decoded
        io_cycle.wr_data = data;
        randomize_lookup(1'($urandom));
        @(negedge clk);
        io_cycle = '0;
    endtask

    task automatic memory_lookup(input logic valid);
        @(negedge clk);
        randomize_lookup(valid);
        @(negedge clk);
    endtask

    // Cycles that no enabled mapper may take
    task automatic ignored_access();
        int         kind;
        logic       rd;
        logic [7:0] port;
        kind = int'($urandom_range(0, 3));
        rd   = 1'($urandom);
        port = 8'hFC | 8'($urandom_range(0, 3));
        case (kind)
            0: io_access(1'b1, 1'b1, rd, ~rd, port, 8'($urandom)); // Interrupt acknowledge
            1: io_access(1'b1, 1'b0, rd, ~rd, 8'($urandom_range(0, 8'hFB)), 8'($urandom));
            2: io_access(1'b1, 1'b0, rd, ~rd, 8'h40 | 8'($urandom_range(0, 3)), 8'($urandom));
            default: io_access(1'b0, 1'b0, rd, ~rd, port, 8'($urandom));
        endcase
    endtask

    task automatic finish_run();
        int total;
        total = error_count + i_dut.i_props.failure_count + (timed_out ? 1 : 0);
        $display("Run complete: %0d value errors, %0d property failures, %0d timeouts",
                 error_count, i_dut.i_props.failure_count, timed_out ? 1 : 0);
        if (total == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    endtask

    initial begin
        logic [7:0] port;
        void'($urandom(RANDOM_SEED));
        clk        = 1'b0;
        reset      = 1'b1;
        io_cycle   = '0;
        mem_lookup = '0;
        cfg[0] = '{enable: 1'b1, port_base: 8'hFC, port_mask: 8'hFC, size: 8'd8};
        cfg[1] = '{enable: 1'b1, port_base: 8'hFC, port_mask: 8'hFC, size: 8'd0};
        cfg[2] = '{enable: 1'b0, port_base: 8'h40, port_mask: 8'hFC, size: 8'd4};
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;

        for (int p = 0; p < 4; p++) begin
            io_access(1'b1, 1'b0, 1'b1, 1'b0, 8'hFC | 8'(p), 8'h00);
        end
        for (int n = 0; n < NUM_PAIRS; n++) begin
            port = 8'hFC | 8'($urandom_range(0, 3));
            io_access(1'b1, 1'b0, 1'b0, 1'b1, port, 8'($urandom));
            io_access(1'b1, 1'b0, 1'b1, 1'b0, port, 8'h00);
        end
        repeat (NUM_IGNORED) ignored_access();
        repeat (NUM_LOOKUPS) memory_lookup(1'($urandom));
        // Registers must still match after the ignored cycles
        for (int p = 0; p < 4; p++) begin
            io_access(1'b1, 1'b0, 1'b1, 1'b0, 8'hFC | 8'(p), 8'h00);
        end
        repeat (2) @(negedge clk);
        finish_run();
    end

    initial begin
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        timed_out = 1'b1;
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        finish_run();
    end

endmodule

`default_nettype wire
